//--- dv/an_tests.txt
// kind word idle los budget neg lacr tx, all hex
// kind 0 reset, 1 wait tx word, 2 wait tx idle, 3 wait negotiating, 4 wait data, 5 hold, 6 quiet
0 0000 0 0 0010 1 0000 0000 // reset
1 0000 0 0 0400 1 0000 0000 // zero words, tx zero /C/
1 0020 0 0 0400 1 0020 0020 // advertise
1 0020 0 0 0400 1 0020 4020 // acknowledge
2 4020 0 0 0400 1 4020 0000 // partner acks, tx goes idle
3 0000 1 0 0400 0 4020 0000 // partner idles, link up
4 0000 1 0 0100 0 4020 0000 // data bytes
3 0000 0 0 0400 1 0000 0000 // breaklink from LINK_OK
1 0000 0 0 0400 1 0000 0000
1 0020 0 0 0400 1 0020 4020 // advertise again
1 4060 0 0 0400 1 4060 0000 // inconsistent ack restarts
5 4060 0 0 0258 1 4060 0000
0 0000 0 1 0010 1 0000 0000 // reset with loss of signal
6 0000 0 1 00c8 1 0000 0000

//--- vlog.f
rtl/an_pkg.sv
rtl/an_link_timer.sv
rtl/an_rx_parser.sv
rtl/an_arbitration.sv
rtl/an_tx_encoder.sv
rtl/an_top.sv
dv/an_asserts.sv
dv/tb_top.sv

//--- dv/tb_top.sv
`timescale 1ns/1ps

module tb_top;

  import an_pkg::*;

  localparam int MAX_STEPS    = 32;
  localparam int RESET_CYCLES = 16;
  localparam int MIN_SETS     = 2;
  localparam int MIN_DATA     = 8;

  // Step kinds in the test file
  localparam int K_RESET     = 0;
  localparam int K_WAIT_CFG  = 1;
  localparam int K_WAIT_IDLE = 2;
  localparam int K_WAIT_NEG  = 3;
  localparam int K_WAIT_DATA = 4;
  localparam int K_HOLD      = 5;
  localparam int K_QUIET     = 6;

  logic         clk;
  logic         mr_main_reset;
  sym_t         rx_byte;
  logic         rx_is_k;
  logic         los;
  sym_t         tx_byte;
  logic         tx_is_k;
  logic         negotiating;
  config_word_t lacr_rx_val;

  logic [31:0]  steps [0:MAX_STEPS*8-1];
  int           error_count;
  int           idx;

  // Link partner state
  config_word_t p_word;
  logic         p_idle;
  config_word_t p_cur_word;
  logic         p_cur_idle;
  int           p_pos;
  logic         p_var;

  // Transmit stream monitor state
  int           m_pos;
  sym_t         m_lo;
  config_word_t c_word;
  int           c_run;
  int           i_run;
  int           d_run;
  sym_t         c_prev;
  logic         c_prev_ok;
  logic         c_rep;
  sym_t         i_prev;
  logic         i_prev_ok;

  an_top #(
    .TIMER_TICKS (64)
  ) uut (
    .clk           (clk),
    .mr_main_reset (mr_main_reset),
    .rx_byte       (rx_byte),
    .rx_is_k       (rx_is_k),
    .los           (los),
    .tx_byte       (tx_byte),
    .tx_is_k       (tx_is_k),
    .negotiating   (negotiating),
    .lacr_rx_val   (lacr_rx_val)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic abort_run(input string msg);
    error_count++;
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  // Partner sends /C/ with C1 then C2, or /I/ with I1 then I2
  task automatic drive_partner();
    case (p_pos)
      0: begin
        rx_byte    = K28_5;
        rx_is_k    = 1'b1;
        p_cur_word = p_word;
        p_cur_idle = p_idle;
        p_pos      = 1;
      end
      1: begin
        rx_is_k = 1'b0;
        if (p_cur_idle) begin
          rx_byte = p_var ? D16_2 : D5_6;
          p_pos   = 0;
        end else begin
          rx_byte = p_var ? D2_2 : D21_5;
          p_pos   = 2;
        end
        p_var = ~p_var;
      end
      2: begin
        rx_byte = p_cur_word[7:0];
        p_pos   = 3;
      end
      default: begin
        rx_byte = p_cur_word[15:8];
        p_pos   = 0;
      end
    endcase
  endtask

  task automatic sample_tx();
    config_word_t word;
    if (mr_main_reset) begin
      m_pos     = 0;
      c_run     = 0;
      i_run     = 0;
      d_run     = 0;
      c_rep     = 1'b0;
      c_prev_ok = 1'b0;
      i_prev_ok = 1'b0;
    end else if (tx_is_k) begin
      assert (tx_byte === K28_5)
        else abort_run($sformatf("error at %0d ns: K symbol %h is not K28.5", $time, tx_byte));
      // A comma inside a set means a restart cut the set short
      if (m_pos != 0) begin
        c_run     = 0;
        c_prev_ok = 1'b0;
      end
      m_pos = 1;
    end else if (m_pos == 0) begin
      assert (tx_byte === 8'h00)
        else abort_run($sformatf("error at %0d ns: data byte %h is not zero", $time, tx_byte));
      d_run++;
      c_run     = 0;
      i_run     = 0;
      c_prev_ok = 1'b0;
      i_prev_ok = 1'b0;
    end else if (m_pos == 1) begin
      if (tx_byte === D2_2 || tx_byte === D21_5) begin
        // Every /C/ run opens with D2.2
        assert (c_prev_ok || tx_byte === D2_2)
          else abort_run($sformatf("error at %0d ns: /C/ run opens with %h", $time, tx_byte));
        // D2.2 twice is a restart at a set boundary, which always changes the word
        c_rep = c_prev_ok && (tx_byte === c_prev);
        assert (!c_rep || tx_byte === D2_2)
          else abort_run($sformatf("error at %0d ns: /C/ byte %h repeats", $time, tx_byte));
        c_prev    = tx_byte;
        c_prev_ok = 1'b1;
        i_prev_ok = 1'b0;
        m_pos     = 2;
      end else begin
        assert (tx_byte === D5_6 || tx_byte === D16_2)
          else abort_run($sformatf("error at %0d ns: bad byte %h after comma", $time, tx_byte));
        // Every /I/ run opens with D5.6 and then alternates
        assert (i_prev_ok ? (tx_byte !== i_prev) : (tx_byte === D5_6))
          else abort_run($sformatf("error at %0d ns: /I/ byte %h out of order", $time, tx_byte));
        i_prev    = tx_byte;
        i_prev_ok = 1'b1;
        i_run++;
        c_run     = 0;
        d_run     = 0;
        c_prev_ok = 1'b0;
        m_pos     = 0;
      end
    end else if (m_pos == 2) begin
      m_lo  = tx_byte;
      m_pos = 3;
    end else begin
      word = {tx_byte, m_lo};
      assert (!c_rep || word != c_word)
        else abort_run($sformatf("error at %0d ns: D2.2 repeats while word %h is unchanged",
                                 $time, word));
      if (c_run > 0 && word == c_word) begin
        c_run++;
      end else begin
        c_word = word;
        c_run  = 1;
      end
      i_run = 0;
      d_run = 0;
      m_pos = 0;
    end
  endtask

  // Outputs are sampled and inputs driven on the falling edge
  task automatic step_cycle();
    @(negedge clk);
    sample_tx();
    assert (uut.u_arbitration.u_asserts.fail_count == 0)
      else abort_run("an assertion bound to the arbitration block failed");
    drive_partner();
  endtask

  task automatic check_levels(input int n, input logic exp_neg, input config_word_t exp_lacr);
    assert (negotiating === exp_neg)
      else abort_run($sformatf("error at %0d ns: step %0d negotiating %b, expected %b",
                               $time, n, negotiating, exp_neg));
    assert (lacr_rx_val === exp_lacr)
      else abort_run($sformatf("error at %0d ns: step %0d lacr_rx_val %h, expected %h",
                               $time, n, lacr_rx_val, exp_lacr));
  endtask

  function automatic bit wait_met(input int kind, input config_word_t exp_tx,
                                  input logic exp_neg);
    case (kind)
      K_WAIT_CFG:  return (c_run >= MIN_SETS) && (c_word == exp_tx);
      K_WAIT_IDLE: return i_run >= MIN_SETS;
      K_WAIT_NEG:  return negotiating === exp_neg;
      default:     return d_run >= MIN_DATA;
    endcase
  endfunction

  task automatic run_step(input int n);
    int           kind;
    int           budget;
    int           cnt;
    logic         exp_neg;
    config_word_t exp_lacr;
    config_word_t exp_tx;
    bit           hit;
    kind     = steps[n*8];
    p_word   = steps[n*8+1][15:0];
    p_idle   = steps[n*8+2][0];
    los      = steps[n*8+3][0];
    budget   = steps[n*8+4];
    exp_neg  = steps[n*8+5][0];
    exp_lacr = steps[n*8+6][15:0];
    exp_tx   = steps[n*8+7][15:0];
    if (kind == K_RESET || kind == K_HOLD || kind == K_QUIET) begin
      if (kind == K_RESET) begin
        mr_main_reset = 1'b1;
        budget        = RESET_CYCLES;
      end
      repeat (budget) begin
        step_cycle();
        assert (negotiating === exp_neg)
          else abort_run($sformatf("error at %0d ns: step %0d negotiating changed to %b",
                                   $time, n, negotiating));
        if (kind != K_HOLD) begin
          assert (tx_byte === 8'h00 && tx_is_k === 1'b0)
            else abort_run($sformatf("error at %0d ns: step %0d tx %h k %b, expected quiet",
                                     $time, n, tx_byte, tx_is_k));
        end
      end
      check_levels(n, exp_neg, exp_lacr);
      mr_main_reset = 1'b0;
    end else begin
      hit = 1'b0;
      cnt = 0;
      while (!hit && cnt < budget) begin
        step_cycle();
        cnt++;
        hit = wait_met(kind, exp_tx, exp_neg);
      end
      assert (hit)
        else abort_run($sformatf("step %0d timed out after %0d cycles", n, budget));
      check_levels(n, exp_neg, exp_lacr);
    end
  endtask

  initial begin
    mr_main_reset = 1'b1;
    rx_byte       = '0;
    rx_is_k       = 1'b0;
    los           = 1'b0;
    p_word        = '0;
    p_idle        = 1'b0;
    p_pos         = 0;
    p_var         = 1'b0;
    m_pos         = 0;
    c_run         = 0;
    error_count   = 0;
    for (idx = 0; idx < MAX_STEPS * 8; idx++) begin
      steps[idx] = '1;
    end
    $readmemh("dv/an_tests.txt", steps);
    assert (steps[0] !== '1)
      else abort_run("the test file dv/an_tests.txt could not be read");
    idx = 0;
    while (idx < MAX_STEPS && steps[idx*8] !== '1) begin
      run_step(idx);
      idx++;
    end
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- dv/an_asserts.sv
`timescale 1ns/1ps

module an_asserts (
  input logic                clk,
  input logic                mr_main_reset,
  input an_pkg::an_state_e   state,
  input an_pkg::xmit_e       xmit,
  input logic                clear_match,
  input logic                timer_start,
  input logic                negotiating
);

  import an_pkg::*;

  int fail_count = 0;

  // Both strobes are one cycle wide
  clear_pulse_a: assert property (@(posedge clk) disable iff (mr_main_reset)
    clear_match |=> !clear_match)
    else begin
      $error("clear_match stayed high for more than one cycle");
      fail_count++;
    end

  start_pulse_a: assert property (@(posedge clk) disable iff (mr_main_reset)
    timer_start |=> !timer_start)
    else begin
      $error("timer_start stayed high for more than one cycle");
      fail_count++;
    end

  // Link comes up only out of the idle detect phase
  link_up_a: assert property (@(posedge clk) disable iff (mr_main_reset)
    $fell(negotiating) |-> ($past(state) == IDLE_DETECT))
    else begin
      $error("negotiating fell without leaving IDLE_DETECT");
      fail_count++;
    end

  // Ability detect always transmits configuration sets
  no_data_a: assert property (@(posedge clk) disable iff (mr_main_reset)
    (state == ABILITY_DETECT) |-> (xmit != XMIT_DATA))
    else begin
      $error("data mode selected during ABILITY_DETECT");
      fail_count++;
    end

endmodule

bind an_arbitration an_asserts u_asserts (
  .clk           (clk),
  .mr_main_reset (mr_main_reset),
  .state         (state),
  .xmit          (xmit),
  .clear_match   (clear_match),
  .timer_start   (timer_start),
  .negotiating   (negotiating)
);

//--- rtl/an_top.sv
`timescale 1ns/1ps

module an_top #(
  // 10 ms at 125 MHz symbol rate
  parameter int TIMER_TICKS = 1250000
) (
  input  logic                 clk,
  input  logic                 mr_main_reset,
  input  an_pkg::sym_t         rx_byte,
  input  logic                 rx_is_k,
  input  logic                 los,
  output an_pkg::sym_t         tx_byte,
  output logic                 tx_is_k,
  output logic                 negotiating,
  output an_pkg::config_word_t lacr_rx_val
);

  import an_pkg::*;

  logic         config_seen;
  logic         ability_match;
  logic         acknowledge_match;
  logic         consistency_match;
  logic         idle_match;
  logic         clear_match;
  logic         ability_window;
  logic         timer_start;
  logic         timer_running;
  logic         timer_done;
  logic         set_restart;
  xmit_e        xmit;
  config_word_t tx_config;

  // Received word doubles as the status readback
  an_rx_parser u_rx_parser (
    .clk               (clk),
    .mr_main_reset     (mr_main_reset),
    .rx_byte           (rx_byte),
    .rx_is_k           (rx_is_k),
    .clear_match       (clear_match),
    .ability_window    (ability_window),
    .rx_config         (lacr_rx_val),
    .config_seen       (config_seen),
    .ability_match     (ability_match),
    .acknowledge_match (acknowledge_match),
    .consistency_match (consistency_match),
    .idle_match        (idle_match)
  );

  an_arbitration u_arbitration (
    .clk               (clk),
    .mr_main_reset     (mr_main_reset),
    .los               (los),
    .rx_config         (lacr_rx_val),
    .config_seen       (config_seen),
    .ability_match     (ability_match),
    .acknowledge_match (acknowledge_match),
    .consistency_match (consistency_match),
    .idle_match        (idle_match),
    .timer_running     (timer_running),
    .timer_done        (timer_done),
    .xmit              (xmit),
    .tx_config         (tx_config),
    .set_restart       (set_restart),
    .clear_match       (clear_match),
    .ability_window    (ability_window),
    .timer_start       (timer_start),
    .negotiating       (negotiating)
  );

  an_link_timer #(
    .TIMER_TICKS (TIMER_TICKS)
  ) u_link_timer (
    .clk           (clk),
    .mr_main_reset (mr_main_reset),
    .start         (timer_start),
    .running       (timer_running),
    .done          (timer_done)
  );

  an_tx_encoder u_tx_encoder (
    .clk           (clk),
    .mr_main_reset (mr_main_reset),
    .xmit          (xmit),
    .tx_config     (tx_config),
    .set_restart   (set_restart),
    .tx_byte       (tx_byte),
    .tx_is_k       (tx_is_k)
  );

endmodule

//--- rtl/an_tx_encoder.sv
`timescale 1ns/1ps

module an_tx_encoder (
  input  logic                 clk,
  input  logic                 mr_main_reset,
  input  an_pkg::xmit_e        xmit,
  input  an_pkg::config_word_t tx_config,
  input  logic                 set_restart,
  output an_pkg::sym_t         tx_byte,
  output logic                 tx_is_k
);

  import an_pkg::*;

  // Position of the next byte within the ordered set
  logic [1:0]   pos;
  logic         variant;
  xmit_e        cur_mode;
  config_word_t cfg_hold;
  logic         set_start;

  // Mode is only picked up at a set boundary
  assign set_start = set_restart || (pos == 2'd0);

  always_ff @(posedge clk) begin
    if (set_start && (xmit == XMIT_CONFIGURATION)) cfg_hold <= tx_config;
  end

  always_ff @(posedge clk) begin
    if (mr_main_reset) begin
      tx_byte  <= '0;
      tx_is_k  <= 1'b0;
      pos      <= 2'd0;
      variant  <= 1'b0;
      cur_mode <= XMIT_DATA;
    end else if (set_start) begin
      cur_mode <= xmit;
      if (set_restart) variant <= 1'b0;
      if (xmit == XMIT_DATA) begin
        tx_byte <= '0;
        tx_is_k <= 1'b0;
        pos     <= 2'd0;
      end else begin
        tx_byte <= K28_5;
        tx_is_k <= 1'b1;
        pos     <= 2'd1;
      end
    end else begin
      tx_is_k <= 1'b0;
      case (pos)
        2'd1: begin
          variant <= ~variant;
          if (cur_mode == XMIT_IDLE) begin
            tx_byte <= variant ? D16_2 : D5_6;
            pos     <= 2'd0;
          end else begin
            tx_byte <= variant ? D21_5 : D2_2;
            pos     <= 2'd2;
          end
        end
        2'd2: begin
          tx_byte <= cfg_hold[7:0];
          pos     <= 2'd3;
        end
        default: begin
          tx_byte <= cfg_hold[15:8];
          pos     <= 2'd0;
        end
      endcase
    end
  end

endmodule

//--- rtl/an_arbitration.sv
`timescale 1ns/1ps

module an_arbitration (
  input  logic                 clk,
  input  logic                 mr_main_reset,
  input  logic                 los,
  input  an_pkg::config_word_t rx_config,
  input  logic                 config_seen,
  input  logic                 ability_match,
  input  logic                 acknowledge_match,
  input  logic                 consistency_match,
  input  logic                 idle_match,
  input  logic                 timer_running,
  input  logic                 timer_done,
  output an_pkg::xmit_e        xmit,
  output an_pkg::config_word_t tx_config,
  output logic                 set_restart,
  output logic                 clear_match,
  output logic                 ability_window,
  output logic                 timer_start,
  output logic                 negotiating
);

  import an_pkg::*;

  an_state_e state;
  an_state_e state_nxt;
  logic      link_det;
  logic      phase_timed;
  logic      phase_done;
  logic      timed_state;
  logic      breaklink;

  // Partner sending an all-zero word asks to restart negotiation
  assign breaklink = ability_match && (rx_config == '0);

  assign timed_state = (state == AN_RESTART) || (state == COMPLETE_ACKNOWLEDGE) ||
                       (state == IDLE_DETECT);

  assign ability_window = (state == ABILITY_DETECT);
  assign negotiating    = (state != LINK_OK);

  // Decisions wait out the first cycle of a state while stale matches clear
  always_comb begin
    state_nxt = state;
    if (state == AN_ENABLE) begin
      state_nxt = los ? AN_DISABLE_LINK_OK : AN_RESTART;
    end else if (!clear_match) begin
      case (state)
        AN_RESTART: begin
          if (phase_done && link_det) state_nxt = ABILITY_DETECT;
        end
        AN_DISABLE_LINK_OK: begin
          if (!los) state_nxt = AN_ENABLE;
        end
        ABILITY_DETECT: begin
          if (ability_match) state_nxt = breaklink ? AN_ENABLE : ACKNOWLEDGE_DETECT;
        end
        ACKNOWLEDGE_DETECT: begin
          if (breaklink || (acknowledge_match && !consistency_match))
            state_nxt = AN_ENABLE;
          else if (acknowledge_match)
            state_nxt = COMPLETE_ACKNOWLEDGE;
        end
        COMPLETE_ACKNOWLEDGE: begin
          if (breaklink) state_nxt = AN_ENABLE;
          else if (phase_done) state_nxt = IDLE_DETECT;
        end
        IDLE_DETECT: begin
          if (breaklink) state_nxt = AN_ENABLE;
          else if (phase_done && idle_match) state_nxt = LINK_OK;
        end
        default: begin
          if (ability_match) state_nxt = AN_ENABLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (mr_main_reset) begin
      link_det <= 1'b0;
    end else if (los) begin
      link_det <= 1'b0;
    end else if (config_seen) begin
      link_det <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (mr_main_reset) begin
      state       <= AN_ENABLE;
      xmit        <= XMIT_DATA;
      tx_config   <= '0;
      clear_match <= 1'b0;
      set_restart <= 1'b0;
      timer_start <= 1'b0;
      phase_timed <= 1'b0;
      phase_done  <= 1'b0;
    end else begin
      clear_match <= 1'b0;
      set_restart <= 1'b0;
      timer_start <= 1'b0;
      // Wait for any earlier period to end before timing this phase
      if (timed_state && !clear_match && !phase_timed && !timer_running) begin
        timer_start <= 1'b1;
        phase_timed <= 1'b1;
      end
      if (timer_done && phase_timed) phase_done <= 1'b1;
      if (state_nxt != state) begin
        state       <= state_nxt;
        clear_match <= (state_nxt != AN_ENABLE);
        phase_timed <= 1'b0;
        phase_done  <= 1'b0;
        case (state_nxt)
          AN_ENABLE:          tx_config <= '0;
          AN_RESTART: begin
            xmit        <= XMIT_CONFIGURATION;
            tx_config   <= '0;
            set_restart <= 1'b1;
          end
          ABILITY_DETECT:     tx_config <= ADV_ABILITY;
          ACKNOWLEDGE_DETECT: tx_config[ACK_BIT] <= 1'b1;
          IDLE_DETECT: begin
            xmit        <= XMIT_IDLE;
            set_restart <= 1'b1;
          end
          AN_DISABLE_LINK_OK: xmit <= XMIT_DATA;
          LINK_OK:            xmit <= XMIT_DATA;
          default: begin
          end
        endcase
      end
    end
  end

endmodule

//--- rtl/an_rx_parser.sv
`timescale 1ns/1ps

module an_rx_parser (
  input  logic                 clk,
  input  logic                 mr_main_reset,
  input  an_pkg::sym_t         rx_byte,
  input  logic                 rx_is_k,
  input  logic                 clear_match,
  input  logic                 ability_window,
  output an_pkg::config_word_t rx_config,
  output logic                 config_seen,
  output logic                 ability_match,
  output logic                 acknowledge_match,
  output logic                 consistency_match,
  output logic                 idle_match
);

  import an_pkg::*;

  localparam int CW = $clog2(MATCH_COUNT);
  localparam config_word_t NO_ACK = ~(config_word_t'(1) << ACK_BIT);

  cr_state_e    cr_state;
  sym_t         lo_byte;
  logic         set_idle;
  config_word_t last_word;
  config_word_t cons_ref;
  logic [CW-1:0] abl_cnt;
  logic [CW-1:0] ack_cnt;
  logic [CW-1:0] idle_cnt;

  logic is_comma;
  logic is_cfg2;
  logic is_idle2;
  logic abl_same;
  logic ack_same;

  assign is_comma = rx_is_k && (rx_byte == K28_5);
  assign is_cfg2  = !rx_is_k && ((rx_byte == D21_5) || (rx_byte == D2_2));
  assign is_idle2 = !rx_is_k && ((rx_byte == D5_6) || (rx_byte == D16_2));

  // Ack bit is left out of the ability comparison
  assign abl_same = (rx_config & NO_ACK) == (last_word & NO_ACK);
  assign ack_same = rx_config[ACK_BIT] && (rx_config == last_word);

  // Ordered-set framing; a stray K inside a /C/ aborts the set
  always_ff @(posedge clk) begin
    if (mr_main_reset) begin
      cr_state    <= CR_IDLE;
      rx_config   <= '0;
      config_seen <= 1'b0;
      set_idle    <= 1'b0;
    end else begin
      config_seen <= 1'b0;
      set_idle    <= 1'b0;
      case (cr_state)
        CR_IDLE: begin
          if (is_comma) cr_state <= CR_GOT_K;
        end
        CR_GOT_K: begin
          if (is_cfg2) begin
            cr_state <= CR_LOW;
          end else if (is_idle2) begin
            set_idle <= 1'b1;
            cr_state <= CR_IDLE;
          end else if (!is_comma) begin
            cr_state <= CR_IDLE;
          end
        end
        CR_LOW: begin
          if (rx_is_k) cr_state <= is_comma ? CR_GOT_K : CR_IDLE;
          else cr_state <= CR_HIGH;
        end
        default: begin
          if (rx_is_k) begin
            cr_state <= is_comma ? CR_GOT_K : CR_IDLE;
          end else begin
            rx_config   <= {rx_byte, lo_byte};
            config_seen <= 1'b1;
            cr_state    <= CR_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cr_state == CR_LOW) lo_byte <= rx_byte;
  end

  // Previous word, plus the reference taken during ability detect
  always_ff @(posedge clk) begin
    if (config_seen) begin
      last_word <= rx_config;
      if (ability_window) cons_ref <= rx_config;
    end
  end

  always_ff @(posedge clk) begin
    if (mr_main_reset || clear_match) begin
      ability_match     <= 1'b0;
      acknowledge_match <= 1'b0;
      consistency_match <= 1'b0;
      idle_match        <= 1'b0;
      abl_cnt           <= '0;
      ack_cnt           <= '0;
      idle_cnt          <= '0;
    end else begin
      if (config_seen && !ability_match) begin
        if (!abl_same) abl_cnt <= '0;
        else if (abl_cnt == CW'(MATCH_COUNT - 1)) ability_match <= 1'b1;
        else abl_cnt <= abl_cnt + 1'b1;
      end
      if (config_seen && !acknowledge_match) begin
        if (!ack_same) begin
          ack_cnt <= '0;
        end else if (ack_cnt == CW'(MATCH_COUNT - 1)) begin
          acknowledge_match <= 1'b1;
          consistency_match <= (rx_config & NO_ACK) == (cons_ref & NO_ACK);
        end else begin
          ack_cnt <= ack_cnt + 1'b1;
        end
      end
      if (set_idle && !idle_match) begin
        if (idle_cnt == CW'(MATCH_COUNT - 1)) idle_match <= 1'b1;
        else idle_cnt <= idle_cnt + 1'b1;
      end
    end
  end

endmodule

//--- rtl/an_link_timer.sv
`timescale 1ns/1ps

module an_link_timer #(
  parameter int TIMER_TICKS = 1250000
) (
  input  logic clk,
  input  logic mr_main_reset,
  input  logic start,
  output logic running,
  output logic done
);

  localparam int CW = $clog2(TIMER_TICKS + 1);

  logic [CW-1:0] count;

  // One-shot count; done lands TIMER_TICKS cycles after the start pulse
  always_ff @(posedge clk) begin
    if (mr_main_reset) begin
      count   <= '0;
      running <= 1'b0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (!running) begin
        if (start) begin
          count   <= CW'(TIMER_TICKS - 1);
          running <= 1'b1;
        end
      end else if (count > CW'(1)) begin
        count <= count - 1'b1;
      end else begin
        done    <= 1'b1;
        running <= 1'b0;
      end
    end
  end

endmodule

//--- rtl/an_pkg.sv
package an_pkg;

  // Decoded 8b/10b symbol, one per clock
  typedef logic [7:0] sym_t;

  // Comma that opens every ordered set
  localparam sym_t K28_5 = 8'hBC;

  // Second byte of /C/, alternating C1 and C2
  localparam sym_t D21_5 = 8'hB5;
  localparam sym_t D2_2  = 8'h42;

  // Second byte of /I/, I1 flips disparity and I2 keeps it
  localparam sym_t D5_6  = 8'hC5;
  localparam sym_t D16_2 = 8'h50;

  // Clause 37 base page register
  typedef logic [15:0] config_word_t;

  localparam int ACK_BIT = 14;

  // Full duplex only, no pause and no next page
  localparam config_word_t ADV_ABILITY = 16'h0020;

  // Consecutive receptions needed before a match is declared
  localparam int MATCH_COUNT = 3;

  typedef enum logic [3:0] {
    AN_ENABLE,
    AN_RESTART,
    AN_DISABLE_LINK_OK,
    ABILITY_DETECT,
    ACKNOWLEDGE_DETECT,
    COMPLETE_ACKNOWLEDGE,
    IDLE_DETECT,
    LINK_OK
  } an_state_e;

  typedef enum logic [1:0] {
    XMIT_IDLE,
    XMIT_CONFIGURATION,
    XMIT_DATA
  } xmit_e;

  typedef enum logic [1:0] {
    CR_IDLE,
    CR_GOT_K,
    CR_LOW,
    CR_HIGH
  } cr_state_e;

endpackage
